//--- sim.f
+incdir+.
raster_pkg.sv
key_pkg.sv
crop_offsets.sv
hblank_gen.sv
vblank_gen.sv
screen_snapshot.sv
display_crop.sv
crop_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the display crop testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module crop_tb \
	-f sim.f -o crop_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/crop_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi
exit 0

//--- crop_tb_model.svh
/*
 * Display crop reference model
 * Offset rules for key events, snapshot sizes and the change counter
 */
`ifndef CROP_TB_MODEL_SVH
`define CROP_TB_MODEL_SVH

logic [11:0] exp_hbl_l;
logic [11:0] exp_hbl_r;
logic [11:0] exp_vbl_t;
logic [11:0] exp_vbl_b;
logic        exp_alt;       // Alt held
logic [1:0]  exp_res;
logic [11:0] exp_hsize;
logic [11:0] exp_vsize;
logic [6:0]  exp_flg;       // Counts modulo 128

task automatic clear_model();
	exp_hbl_l = '0;
	exp_hbl_r = '0;
	exp_vbl_t = '0;
	exp_vbl_b = '0;
	exp_alt = 1'b0;
	exp_res = '0;
	exp_hsize = '0;
	exp_vsize = '0;
	exp_flg = '0;
endtask

// One accepted key event
task automatic apply_key(input logic [7:0] code);
	case (code)
		`KEY_BACKSPACE: begin
			exp_hbl_l = '0;
			exp_hbl_r = '0;
			exp_vbl_t = '0;
			exp_vbl_b = '0;
		end
		`KEY_UP: begin
			if (exp_alt) exp_vbl_b = 12'(exp_vbl_b + `CROP_V_STEP);
			else         exp_vbl_t = 12'(exp_vbl_t + `CROP_V_STEP);
		end
		`KEY_DOWN: begin
			if (exp_alt) exp_vbl_b = 12'(exp_vbl_b - `CROP_V_STEP);
			else         exp_vbl_t = 12'(exp_vbl_t - `CROP_V_STEP);
		end
		`KEY_LEFT: begin
			if (exp_alt) exp_hbl_r = 12'(exp_hbl_r + `CROP_H_STEP);
			else         exp_hbl_l = 12'(exp_hbl_l + `CROP_H_STEP);
		end
		`KEY_RIGHT: begin
			if (exp_alt) exp_hbl_r = 12'(exp_hbl_r - `CROP_H_STEP);
			else         exp_hbl_l = 12'(exp_hbl_l - `CROP_H_STEP);
		end
		`KEY_ALT_L_DN, `KEY_ALT_R_DN: exp_alt = 1'b1;
		`KEY_ALT_L_UP, `KEY_ALT_R_UP: exp_alt = 1'b0;
		default: ;
	endcase
endtask

// Frame snapshot, counter steps when anything measured differs
task automatic take_snapshot(input logic [1:0] res_in, input int hsize_in, input int vsize_in);
	if (res_in != exp_res || 12'(hsize_in) != exp_hsize || 12'(vsize_in) != exp_vsize)
		exp_flg = 7'(exp_flg + 1);
	exp_res = res_in;
	exp_hsize = 12'(hsize_in);
	exp_vsize = 12'(vsize_in);
endtask

`endif

//--- crop_tb.sv
/*
 * Display crop testbench
 * Random raster geometry and key events, checked against a model
 */
`timescale 1ns/1ns
`default_nettype none
`include "crop_consts.svh"

module crop_tb;

	localparam int FRAMES = 24;
	localparam int SYNC_LEN = 6;       // hs low cycles per line
	localparam int BLANK_LINES = 4;    // Leading blank lines with vs low on lines 1 and 2
	localparam int MID_LINE = BLANK_LINES + 8;
	localparam int CYCLE_LIMIT = FRAMES * (BLANK_LINES + 40) * 160 + 200;

	logic clk_sys = 1'b0;
	logic reset;
	logic hs, vs, hblank, vblank_in;
	raster_pkg::res_t res;
	key_pkg::key_code_t kbd_data;
	key_pkg::event_type_t kbd_type;
	logic kbd_level;
	logic hde, vde;
	raster_pkg::count_t scr_hbl_l, scr_hbl_r, scr_vbl_t, scr_hsize, scr_vsize;
	raster_pkg::bottom_edge_u scr_vbl_b;
	raster_pkg::res_t scr_res;
	logic [6:0] scr_flg;

	integer seed = 32'h91c6_dea7;
	int cycle_count = 0;
	int line_len, act_w, act_x, act_lines, prev_lines;
	logic [1:0] res_now;
	logic key_level;

	`include "crop_tb_model.svh"

	display_crop UUT (
		.clk_sys(clk_sys), .reset(reset), .hs(hs), .vs(vs), .hblank(hblank),
		.vblank_in(vblank_in), .res(res), .kbd_data(kbd_data), .kbd_type(kbd_type),
		.kbd_level(kbd_level), .hde(hde), .vde(vde), .scr_hbl_l(scr_hbl_l),
		.scr_hbl_r(scr_hbl_r), .scr_vbl_t(scr_vbl_t), .scr_vbl_b(scr_vbl_b),
		.scr_hsize(scr_hsize), .scr_vsize(scr_vsize), .scr_res(scr_res), .scr_flg(scr_flg)
	);

	always #10 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the raster did not finish within %0d cycles", CYCLE_LIMIT);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	end

	function int rand_range(input int lo, input int hi);
		logic [31:0] r;
		r = $random(seed);
		return lo + int'(r % (hi - lo + 1));
	endfunction

	task automatic expect_equal(input string what, input int got, input int exp);
		assert (got == exp) else begin
			$display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	endtask

	function logic [7:0] pick_code();
		case (rand_range(0, 12))
			0, 1:    return `KEY_UP;
			2, 3:    return `KEY_DOWN;
			4, 5:    return `KEY_LEFT;
			6, 7:    return `KEY_RIGHT;
			8:       return `KEY_BACKSPACE;
			9:       return rand_range(0, 1) ? `KEY_ALT_L_DN : `KEY_ALT_R_DN;
			10:      return rand_range(0, 1) ? `KEY_ALT_L_UP : `KEY_ALT_R_UP;
			default: return 8'(rand_range(0, 255));
		endcase
	endfunction

	task automatic send_valid_key(input logic [7:0] code);
		kbd_type <= `CROP_KEY_TYPE;
		kbd_data <= code;
		key_level = ~key_level;
		kbd_level <= key_level;
		apply_key(code);
	endtask

	// Mix of valid events, wrong type toggles and type-3 codes without a toggle
	task automatic send_random_key();
		int kind;
		logic [7:0] code;
		kind = rand_range(0, 5);
		code = pick_code();
		if (kind < 4) begin
			send_valid_key(code);
		end else if (kind == 4) begin
			kbd_type <= 2'(rand_range(0, 2));
			kbd_data <= code;
			key_level = ~key_level;
			kbd_level <= key_level;
		end else begin
			kbd_type <= `CROP_KEY_TYPE;
			kbd_data <= code;
		end
	endtask

	task automatic check_snapshot();
		take_snapshot(res_now, act_w, prev_lines);
		expect_equal("scr_hbl_l", scr_hbl_l, exp_hbl_l);
		expect_equal("scr_hbl_r", scr_hbl_r, exp_hbl_r);
		expect_equal("scr_vbl_t", scr_vbl_t, exp_vbl_t);
		expect_equal("scr_vbl_b", scr_vbl_b.line, exp_vbl_b);
		expect_equal("scr_hsize", scr_hsize, exp_hsize);
		expect_equal("scr_vsize", scr_vsize, exp_vsize);
		expect_equal("scr_res", scr_res, exp_res);
		expect_equal("scr_flg", scr_flg, exp_flg);
	endtask

	// Overlap of the cropped and forced windows in cycles
	function int window_overlap();
		int lo, hi;
		lo = (act_x - 1 > SYNC_LEN + `CROP_H_MARGIN + 1) ?
			act_x - 1 : SYNC_LEN + `CROP_H_MARGIN + 1;
		hi = (act_x + act_w - 2 < line_len - `CROP_H_MARGIN) ?
			act_x + act_w - 2 : line_len - `CROP_H_MARGIN;
		return (hi >= lo) ? hi - lo + 1 : 0;
	endfunction

	task automatic run_frame(input int frame);
		int line, c, gap, hde_count;
		gap = 0;
		hde_count = 0;
		for (line = 0; line < BLANK_LINES + act_lines; line++) begin
			for (c = 0; c < line_len; c++) begin
				@(posedge clk_sys);
				hs <= (c >= SYNC_LEN);
				hblank <= !(c >= act_x && c < act_x + act_w);
				vblank_in <= (line < BLANK_LINES);
				vs <= !(line == 1 || line == 2);
				res <= res_now;
				if (gap > 0) gap--;
				if (line < 2 && c >= 2 && c < line_len - 2 && gap == 0 &&
					rand_range(0, 7) == 0) begin
					send_random_key();
					gap = 2;
				end
				if (frame % 4 == 3 && line == 2 && c == 5) send_valid_key(`KEY_BACKSPACE);
				@(negedge clk_sys);
				if (line == BLANK_LINES && c == 2) check_snapshot();
				if (frame % 4 == 3 && line == MID_LINE) begin
					if (hde) hde_count++;
					if (c == line_len - 1) begin
						expect_equal("hde cycles", hde_count, window_overlap());
						expect_equal("vde", vde, 1);
					end
				end
			end
		end
	endtask

	initial begin
		int frame;
		reset <= 1'b1;
		hs <= 1'b1;
		vs <= 1'b1;
		hblank <= 1'b1;
		vblank_in <= 1'b0;
		res <= '0;
		kbd_data <= '0;
		kbd_type <= '0;
		kbd_level <= 1'b0;
		key_level = 1'b0;
		res_now = '0;
		prev_lines = 0;
		clear_model();
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
		@(posedge clk_sys);
		@(negedge clk_sys);
		expect_equal("hde after reset", hde, 0);
		expect_equal("vde after reset", vde, 0);
		expect_equal("scr_flg after reset", scr_flg, 0);
		expect_equal("scr_hsize after reset", scr_hsize, 0);
		expect_equal("scr_vsize after reset", scr_vsize, 0);
		expect_equal("scr_hbl_l after reset", scr_hbl_l, 0);
		expect_equal("scr_hbl_r after reset", scr_hbl_r, 0);
		expect_equal("scr_vbl_t after reset", scr_vbl_t, 0);
		expect_equal("scr_vbl_b after reset", scr_vbl_b.line, 0);
		expect_equal("scr_res after reset", scr_res, 0);

		for (frame = 0; frame < FRAMES; frame++) begin
			if (frame == 0 || rand_range(0, 1) == 1) begin    // Often keep the geometry
				line_len = rand_range(100, 160);
				act_w = rand_range(60, (line_len - 14 < 100) ? line_len - 14 : 100);
				act_x = rand_range(SYNC_LEN + 2, line_len - act_w - 2);
				act_lines = rand_range(20, 40);
			end
			if (rand_range(0, 2) == 0) res_now = 2'(rand_range(0, 3));
			run_frame(frame);
			prev_lines = act_lines;
		end

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- display_crop.sv
/*
 * Display crop top level
 * Keyboard trimmed blanking with a per-frame geometry snapshot
 */
`timescale 1ns/1ns
`default_nettype none

module display_crop (
	input  wire                       clk_sys,
	input  wire                       reset,
	input  wire                       hs,
	input  wire                       vs,
	input  wire                       hblank,
	input  wire                       vblank_in,
	input  wire raster_pkg::res_t     res,
	input  wire key_pkg::key_code_t   kbd_data,
	input  wire key_pkg::event_type_t kbd_type,
	input  wire                       kbd_level,
	output logic                      hde,
	output logic                      vde,
	output raster_pkg::count_t        scr_hbl_l,
	output raster_pkg::count_t        scr_hbl_r,
	output raster_pkg::count_t        scr_vbl_t,
	output raster_pkg::bottom_edge_u  scr_vbl_b,
	output raster_pkg::count_t        scr_hsize,
	output raster_pkg::count_t        scr_vsize,
	output raster_pkg::res_t          scr_res,
	output logic [6:0]                scr_flg
);

	raster_pkg::count_t       hbl_l;
	raster_pkg::count_t       hbl_r;
	raster_pkg::count_t       vbl_t;
	raster_pkg::bottom_edge_u vbl_b;
	raster_pkg::count_t       hsize;
	raster_pkg::count_t       vsize;
	logic                     hbl_n;
	logic                     vcnt_is_one;
	logic                     frame_start;

	crop_offsets u_offsets (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.kbd_data  (kbd_data),
		.kbd_type  (kbd_type),
		.kbd_level (kbd_level),
		.hbl_l     (hbl_l),
		.hbl_r     (hbl_r),
		.vbl_t     (vbl_t),
		.vbl_b     (vbl_b)
	);

	hblank_gen u_hblank (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.hs          (hs),
		.hblank      (hblank),
		.vcnt_is_one (vcnt_is_one),
		.hbl_l       (hbl_l),
		.hbl_r       (hbl_r),
		.hbl_n       (hbl_n),
		.hde         (hde),
		.hsize       (hsize)
	);

	vblank_gen u_vblank (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.hs          (hs),
		.vs          (vs),
		.vblank_in   (vblank_in),
		.hbl_n       (hbl_n),
		.vbl_t       (vbl_t),
		.vbl_b       (vbl_b),
		.vde         (vde),
		.vcnt_is_one (vcnt_is_one),
		.frame_start (frame_start),
		.vsize       (vsize)
	);

	screen_snapshot u_snapshot (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.frame_start (frame_start),
		.hbl_l       (hbl_l),
		.hbl_r       (hbl_r),
		.vbl_t       (vbl_t),
		.vbl_b       (vbl_b),
		.hsize       (hsize),
		.vsize       (vsize),
		.res         (res),
		.scr_hbl_l   (scr_hbl_l),
		.scr_hbl_r   (scr_hbl_r),
		.scr_vbl_t   (scr_vbl_t),
		.scr_vbl_b   (scr_vbl_b),
		.scr_hsize   (scr_hsize),
		.scr_vsize   (scr_vsize),
		.scr_res     (scr_res),
		.scr_flg     (scr_flg)
	);

endmodule

`default_nettype wire

//--- screen_snapshot.sv
/*
 * Screen geometry snapshot
 * Copies offsets, sizes and resolution once per frame
 * and counts the frames where resolution or size changed
 */
`timescale 1ns/1ns
`default_nettype none

module screen_snapshot (
	input  wire                           clk_sys,
	input  wire                           reset,
	input  wire                           frame_start,
	input  wire raster_pkg::count_t       hbl_l,
	input  wire raster_pkg::count_t       hbl_r,
	input  wire raster_pkg::count_t       vbl_t,
	input  wire raster_pkg::bottom_edge_u vbl_b,
	input  wire raster_pkg::count_t       hsize,
	input  wire raster_pkg::count_t       vsize,
	input  wire raster_pkg::res_t         res,
	output raster_pkg::count_t            scr_hbl_l,
	output raster_pkg::count_t            scr_hbl_r,
	output raster_pkg::count_t            scr_vbl_t,
	output raster_pkg::bottom_edge_u      scr_vbl_b,
	output raster_pkg::count_t            scr_hsize,
	output raster_pkg::count_t            scr_vsize,
	output raster_pkg::res_t              scr_res,
	output logic [6:0]                    scr_flg     // Change counter, wraps
);

	logic changed;

	// Compared against the copy still held from the last frame
	assign changed = (scr_res != res) || (scr_hsize != hsize) || (scr_vsize != vsize);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			scr_hbl_l <= '0;
			scr_hbl_r <= '0;
			scr_vbl_t <= '0;
			scr_vbl_b <= '0;
			scr_hsize <= '0;
			scr_vsize <= '0;
			scr_res <= '0;
			scr_flg <= '0;
		end else if (frame_start) begin
			scr_hbl_l <= hbl_l;
			scr_hbl_r <= hbl_r;
			scr_vbl_t <= vbl_t;
			scr_vbl_b <= vbl_b;
			scr_hsize <= hsize;
			scr_vsize <= vsize;
			scr_res <= res;
			if (changed) scr_flg <= scr_flg + 1'd1;
		end
	end

endmodule

`default_nettype wire

//--- vblank_gen.sv
/*
 * Vertical blank generator
 * Counts lines, measures the frame and applies the top and bottom crop
 * Also forces blank around vertical sync and marks the start of each frame
 */
`timescale 1ns/1ns
`default_nettype none
`include "crop_consts.svh"

module vblank_gen (
	input  wire                           clk_sys,
	input  wire                           reset,
	input  wire                           hs,          // Active low
	input  wire                           vs,          // Active low
	input  wire                           vblank_in,
	input  wire                           hbl_n,
	input  wire raster_pkg::count_t       vbl_t,
	input  wire raster_pkg::bottom_edge_u vbl_b,
	output logic                          vde,
	output logic                          vcnt_is_one,
	output logic                          frame_start,
	output raster_pkg::count_t            vsize
);

	raster_pkg::count_t vcnt;
	raster_pkg::count_t vend;      // Last blank line before active area
	raster_pkg::count_t vmax;      // Line count of the frame
	raster_pkg::count_t vs_end;    // Line where sync ends
	raster_pkg::count_t open_at;
	raster_pkg::count_t close_at;
	logic old_vs;
	logic old_hs;
	logic old_vblank;
	logic old_hbl_n;
	logic vblank;                  // Source blank or sync
	logic vblank_rise;
	logic line_check;
	logic crop_open;
	logic force_open;

	assign vblank = vblank_in | ~vs;
	assign vblank_rise = ~old_vblank & vblank;
	assign frame_start = old_vblank & ~vblank;
	assign vcnt_is_one = (vcnt == `CROP_CNT_W'(1));

	assign open_at = vend + vbl_t;
	assign close_at = raster_pkg::bottom_line(vbl_b, vmax);

	// Edges are tested at each start of active pixels, and all through line 0
	assign line_check = (~old_hbl_n & hbl_n) | (vcnt == '0);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_vs <= 1'b0;
			old_hs <= 1'b0;
			old_vblank <= 1'b0;
			old_hbl_n <= 1'b0;
			vcnt <= '0;
			vend <= '0;
			vmax <= '0;
			vs_end <= '0;
			vsize <= '0;
			crop_open <= 1'b0;
			force_open <= 1'b0;
			vde <= 1'b0;
		end else begin
			old_vs <= vs;
			old_hs <= hs;
			old_vblank <= vblank;
			old_hbl_n <= hbl_n;
			vde <= crop_open & force_open;

			if (old_hs & ~hs) vcnt <= vcnt + 1'd1;
			if (vblank_rise) vcnt <= '0;          // Restart wins over the step

			if (frame_start) vend <= vcnt;
			if (~old_vs & vs) vs_end <= vcnt;
			if (vblank_rise) begin
				vmax <= vcnt;
				vsize <= vcnt - vend;
			end

			if (line_check) begin
				if (vcnt == open_at) crop_open <= 1'b1;
				if (vcnt == close_at) crop_open <= 1'b0;

				// Forced blank from the line before the end through sync
				if (vcnt == vmax - 1'd1) force_open <= 1'b0;
				if (vcnt == vs_end + 2'd2) force_open <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hblank_gen.sv
/*
 * Horizontal blank generator
 * Measures the line, applies the left and right crop and the forced edge blank
 */
`timescale 1ns/1ns
`default_nettype none
`include "crop_consts.svh"

module hblank_gen (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire                     hs,           // Active low
	input  wire                     hblank,
	input  wire                     vcnt_is_one,
	input  wire raster_pkg::count_t hbl_l,
	input  wire raster_pkg::count_t hbl_r,
	output logic                    hbl_n,        // High inside active window
	output logic                    hde,
	output raster_pkg::count_t      hsize
);

	localparam raster_pkg::count_t MARGIN = `CROP_H_MARGIN;

	raster_pkg::count_t hcnt;
	raster_pkg::count_t hend;      // Count where source blank ends
	raster_pkg::count_t hsta;      // Count where source blank starts
	raster_pkg::count_t hmax;      // Line length
	raster_pkg::count_t crop_open_at;
	raster_pkg::count_t crop_close_at;
	raster_pkg::count_t force_close_at;
	logic old_hs;
	logic old_hblank;
	logic crop_open;               // Inside the cropped window
	logic force_open;              // Clear of the forced margins
	logic hblank_fall;
	logic hblank_rise;

	assign hblank_fall = old_hblank & ~hblank;
	assign hblank_rise = ~old_hblank & hblank;

	// Window edges, two counts early to line up with the source blank
	assign crop_open_at = hend + hbl_l - 2'd2;
	assign crop_close_at = hsta + hbl_r - 2'd2;
	assign force_close_at = hmax - MARGIN;

	assign hbl_n = crop_open & force_open & hs;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_hs <= 1'b0;
			old_hblank <= 1'b0;
			hcnt <= '0;
			hend <= '0;
			hsta <= '0;
			hmax <= '0;
			hsize <= '0;
			crop_open <= 1'b0;
			force_open <= 1'b0;
			hde <= 1'b0;
		end else begin
			old_hs <= hs;
			old_hblank <= hblank;
			hde <= hbl_n;
			hcnt <= hs ? hcnt + 1'd1 : '0;    // Held at zero through sync

			if (hblank_fall) hend <= hcnt;
			if (hblank_rise) hsta <= hcnt;
			if (old_hs & ~hs) hmax <= hcnt;

			if (hcnt == crop_open_at) crop_open <= 1'b1;
			if (hcnt == crop_close_at) crop_open <= 1'b0;

			if (hcnt == MARGIN) force_open <= 1'b1;
			if (hcnt == force_close_at) force_open <= 1'b0;

			// Width taken on one fixed line per frame
			if (hblank_rise & vcnt_is_one) hsize <= hcnt - hend;
		end
	end

endmodule

`default_nettype wire

//--- crop_offsets.sv
/*
 * Crop offset registers
 * Turns keyboard events into the four blanking edge offsets
 * Alt held moves the opposite edge, Backspace clears all four
 */
`timescale 1ns/1ns
`default_nettype none
`include "crop_consts.svh"

module crop_offsets (
	input  wire                       clk_sys,
	input  wire                       reset,
	input  wire key_pkg::key_code_t   kbd_data,
	input  wire key_pkg::event_type_t kbd_type,
	input  wire                       kbd_level,    // Toggles once per event
	output raster_pkg::count_t        hbl_l,
	output raster_pkg::count_t        hbl_r,
	output raster_pkg::count_t        vbl_t,
	output raster_pkg::bottom_edge_u  vbl_b
);

	localparam raster_pkg::count_t H_STEP = `CROP_H_STEP;
	localparam raster_pkg::count_t V_STEP = `CROP_V_STEP;

	logic old_level;
	logic alt;          // Either Alt key held
	logic key_event;

	assign key_event = (old_level ^ kbd_level) && (kbd_type == `CROP_KEY_TYPE);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_level <= 1'b0;
			alt <= 1'b0;
			hbl_l <= '0;
			hbl_r <= '0;
			vbl_t <= '0;
			vbl_b <= '0;
		end else begin
			old_level <= kbd_level;
			if (key_event) begin
				case (kbd_data)
					`KEY_BACKSPACE: begin
						hbl_l <= '0;
						hbl_r <= '0;
						vbl_t <= '0;
						vbl_b <= '0;
					end
					`KEY_UP: begin
						if (alt) vbl_b.line <= vbl_b.line + V_STEP;
						else     vbl_t <= vbl_t + V_STEP;
					end
					`KEY_DOWN: begin
						if (alt) vbl_b.line <= vbl_b.line - V_STEP;
						else     vbl_t <= vbl_t - V_STEP;
					end
					`KEY_LEFT: begin
						if (alt) hbl_r <= hbl_r + H_STEP;
						else     hbl_l <= hbl_l + H_STEP;
					end
					`KEY_RIGHT: begin
						if (alt) hbl_r <= hbl_r - H_STEP;
						else     hbl_l <= hbl_l - H_STEP;
					end
					default: begin
						// Track modifier, other codes are ignored
						if (key_pkg::is_alt_down(kbd_data)) begin
							alt <= 1'b1;
						end else if (key_pkg::is_alt_up(kbd_data)) begin
							alt <= 1'b0;
						end
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- key_pkg.sv
/*
 * Keyboard event types
 * Key code and event type words, plus Alt key decoding
 */
`default_nettype none
`include "crop_consts.svh"

package key_pkg;

	typedef logic [7:0] key_code_t;      // Raw key code
	typedef logic [1:0] event_type_t;    // Which kind of event the code belongs to

	// Either Alt key pressed
	function automatic logic is_alt_down(key_code_t code);
		return (code == `KEY_ALT_L_DN) || (code == `KEY_ALT_R_DN);
	endfunction

	// Either Alt key released
	function automatic logic is_alt_up(key_code_t code);
		return (code == `KEY_ALT_L_UP) || (code == `KEY_ALT_R_UP);
	endfunction

endpackage

`default_nettype wire

//--- raster_pkg.sv
/*
 * Raster types
 * Pixel and line counts, resolution flags and the bottom crop word
 */
`default_nettype none
`include "crop_consts.svh"

package raster_pkg;

	typedef logic [`CROP_CNT_W-1:0] count_t;    // Pixel or line count
	typedef logic [1:0] res_t;                   // Source resolution flags

	// Bottom crop edge
	// Top bit clear means an absolute line, set means a distance back from the last line
	typedef union packed {
		count_t                        line;
		logic signed [`CROP_CNT_W-1:0] from_end;
	} bottom_edge_u;

	// Line on which the cropped window closes
	function automatic count_t bottom_line(bottom_edge_u b, count_t vmax);
		count_t close_at;
		if (b.from_end < 0) begin
			close_at = vmax + count_t'(b.from_end);
		end else begin
			close_at = b.line;
		end
		return close_at;
	endfunction

endpackage

`default_nettype wire

//--- crop_consts.svh
/*
 * Display crop constants
 * Counter width, offset steps, forced blank margin and keyboard codes
 */
`ifndef CROP_CONSTS_SVH
`define CROP_CONSTS_SVH

`define CROP_CNT_W     12       // Raster counter width
`define CROP_H_STEP    4        // Pixels per left or right press
`define CROP_V_STEP    1        // Lines per up or down press
`define CROP_H_MARGIN  8        // Forced blank at each line edge
`define CROP_KEY_TYPE  3        // Event type that carries key codes

// Cursor and edit keys
`define KEY_BACKSPACE  'h41
`define KEY_UP         'h4c
`define KEY_DOWN       'h4d
`define KEY_LEFT       'h4f
`define KEY_RIGHT      'h4e

// Alt press and release, left and right
`define KEY_ALT_L_DN   'h64
`define KEY_ALT_R_DN   'h65
`define KEY_ALT_L_UP   'hE4
`define KEY_ALT_R_UP   'hE5

`endif
